//--- spi_loop_top.f
design/spi_loop_pkg.sv
design/spi_master.sv
design/transfer_sequencer.sv
design/loopback_checker.sv
design/spi_loop_top.sv
test/spi_echo_model.sv
test/tb_spi_loop.sv

//--- test/tb_spi_loop.sv
module tb_spi_loop;
    import spi_loop_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int GAP_TIMEOUT = 100;
    localparam int FRAME_TIMEOUT = 400;

    logic               clk;
    logic               rst;
    logic               miso;
    logic               sclk;
    logic               mosi;
    logic               cs;
    logic               led_red;
    logic               led_green;
    logic               led_blue;
    logic               error;
    logic [RX_PINS-1:0] rx_pins;
    logic               fault;

    // Monitor state updated once per falling clock edge
    int                   high_cnt;
    int                   rise_cnt;
    logic                 prev_sclk;
    logic                 cs_fell;
    int                   fault_frame;
    int                   i;
    int                   n;
    logic [WORD_BITS-1:0] expected;
    logic [WORD_BITS-1:0] echoed;

    spi_loop_top UUT (
        .clk       (clk),
        .rst       (rst),
        .miso      (miso),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs        (cs),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue),
        .error     (error),
        .rx_pins   (rx_pins)
    );

    spi_echo_model u_echo (
        .sclk  (sclk),
        .mosi  (mosi),
        .cs    (cs),
        .fault (fault),
        .miso  (miso)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            report_failure($sformatf("CHECK FAILED %s expected %0h actual %0h",
                                     name, exp_val, act_val));
        end
    endtask

    // Advance to the next falling edge and run the checks that always apply
    task automatic tick();
        @(negedge clk);
        if (cs === 1'b1) begin
            high_cnt++;
            check_equal("sclk idle while cs high", 32'd0, sclk);
        end else begin
            cs_fell = 1'b1;
        end
        if (cs === 1'b0 && prev_sclk === 1'b0 && sclk === 1'b1) begin
            rise_cnt++;
        end
        prev_sclk = sclk;
        if (cs_fell) begin
            check_equal("led_blue while running", LED_ON, led_blue);
        end
    endtask

    task automatic wait_for_cs(input logic level, input int limit, input string what);
        int waited;
        waited = 0;
        while (cs !== level) begin
            if (waited == limit) begin
                report_failure($sformatf("Timed out waiting for %s", what));
            end
            tick();
            waited++;
        end
    endtask

    initial begin
        void'($urandom(32'h2700a9cd));
        fault_frame = 2 + ($urandom % 6);
        rst = 1'b1;
        fault = 1'b0;
        high_cnt = 0;
        rise_cnt = 0;
        prev_sclk = 1'b0;
        cs_fell = 1'b0;

        for (i = 0; i < RESET_CYCLES; i++) begin
            tick();
            check_equal("reset cs", 32'd1, cs);
            check_equal("reset error", 32'd0, error);
            check_equal("reset led_red", LED_OFF, led_red);
            check_equal("reset led_green", LED_OFF, led_green);
            check_equal("reset led_blue", LED_OFF, led_blue);
        end
        rst = 1'b0;

        // Nothing may move during the power-up delay
        for (i = 1; i <= START_DELAY; i++) begin
            tick();
            check_equal("delay cs", 32'd1, cs);
            check_equal("delay error", 32'd0, error);
            check_equal("delay led_red", LED_OFF, led_red);
            check_equal("delay led_green", LED_OFF, led_green);
            if (i < START_DELAY) begin
                check_equal("delay led_blue", LED_OFF, led_blue);
            end
        end

        for (n = 0; n <= fault_frame + 3; n++) begin
            if (n == fault_frame) begin
                fault = 1'b1;
            end
            wait_for_cs(1'b0, GAP_TIMEOUT, "cs to fall");
            assert (high_cnt >= 2) else begin
                report_failure($sformatf("CHECK FAILED frame spacing expected >= 2 actual %0d",
                                         high_cnt));
            end
            high_cnt = 0;
            rise_cnt = 0;

            wait_for_cs(1'b1, FRAME_TIMEOUT, "cs to rise");
            if (n == fault_frame) begin
                fault = 1'b0;
            end
            check_equal("sclk edges per frame", WORD_BITS, rise_cnt);
            check_equal("frame count", n + 1, u_echo.frames.size());
            expected = TX_SEED + WORD_BITS'(n) * TX_STEP;
            check_equal("frame word", expected, u_echo.frames[n]);

            // Checker outputs settle one cycle after done
            tick();
            tick();
            echoed = (n == fault_frame) ? ~expected : expected;
            check_equal("rx_pins", echoed[RX_PINS-1:0], rx_pins);
            if (n >= fault_frame) begin
                check_equal("error after fault", 32'd1, error);
                check_equal("led_red after fault", LED_ON, led_red);
                check_equal("led_green after fault", LED_OFF, led_green);
            end else begin
                check_equal("error before fault", 32'd0, error);
                check_equal("led_red before fault", LED_OFF, led_red);
                check_equal("led_green before fault", LED_ON, led_green);
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- test/spi_echo_model.sv
module spi_echo_model (
    input  logic sclk,
    input  logic mosi,
    input  logic cs,
    input  logic fault,
    output logic miso
);
    import spi_loop_pkg::*;

    // Every completed MOSI frame, oldest first
    logic [WORD_BITS-1:0] frames[$];

    logic [WORD_BITS-1:0] shift;
    int                   bit_cnt;

    initial begin
        shift = '0;
        bit_cnt = 0;
    end

    // Loopback wire, optionally inverted to force a mismatch
    assign miso = fault ? ~mosi : mosi;

    // New frame starts with chip select
    always @(negedge cs) begin
        shift = '0;
        bit_cnt = 0;
    end

    // Mode 0 slave samples on the rising SCLK edge
    always @(posedge sclk) begin
        if (cs === 1'b0) begin
            shift = {shift[WORD_BITS-2:0], mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == WORD_BITS) begin
                frames.push_back(shift);
            end
        end
    end

endmodule

//--- design/spi_loop_top.sv
module spi_loop_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             miso,
    output logic                             sclk,
    output logic                             mosi,
    output logic                             cs,
    output logic                             led_red,
    output logic                             led_green,
    output logic                             led_blue,
    output logic                             error,
    output logic [spi_loop_pkg::RX_PINS-1:0] rx_pins
);
    import spi_loop_pkg::*;

    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 running;
    logic [WORD_BITS-1:0] tx_word;
    logic [WORD_BITS-1:0] rx_word;

    // Generates the word stream and the start requests
    transfer_sequencer u_sequencer (
        .clk     (clk),
        .rst     (rst),
        .busy    (busy),
        .done    (done),
        .start   (start),
        .tx_word (tx_word),
        .running (running)
    );

    spi_master u_master (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .tx_word (tx_word),
        .miso    (miso),
        .busy    (busy),
        .done    (done),
        .rx_word (rx_word),
        .sclk    (sclk),
        .mosi    (mosi),
        .cs      (cs)
    );

    // Status outputs for the board
    loopback_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .running   (running),
        .done      (done),
        .tx_word   (tx_word),
        .rx_word   (rx_word),
        .error     (error),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue),
        .rx_pins   (rx_pins)
    );

endmodule

//--- design/loopback_checker.sv
module loopback_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               running,
    input  logic                               done,
    input  logic [spi_loop_pkg::WORD_BITS-1:0] tx_word,
    input  logic [spi_loop_pkg::WORD_BITS-1:0] rx_word,
    output logic                               error,
    output logic                               led_red,
    output logic                               led_green,
    output logic                               led_blue,
    output logic [spi_loop_pkg::RX_PINS-1:0]   rx_pins
);
    import spi_loop_pkg::*;

    // At least one transfer came back intact
    logic good_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
            good_seen <= 1'b0;
            rx_pins <= '0;
        end else if (done) begin
            rx_pins <= rx_word[RX_PINS-1:0];
            if (rx_word != tx_word) begin
                // Sticky until the next reset
                error <= 1'b1;
            end else begin
                good_seen <= 1'b1;
            end
        end
    end

    assign led_blue = running ? LED_ON : LED_OFF;
    assign led_red = error ? LED_ON : LED_OFF;

    // Green goes dark again once any error shows up
    assign led_green = (good_seen && !error) ? LED_ON : LED_OFF;

endmodule

//--- design/transfer_sequencer.sv
module transfer_sequencer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               busy,
    input  logic                               done,
    output logic                               start,
    output logic [spi_loop_pkg::WORD_BITS-1:0] tx_word,
    output logic                               running
);
    import spi_loop_pkg::*;

    localparam int DELAY_W = (START_DELAY > 1) ? $clog2(START_DELAY) : 1;
    localparam logic [DELAY_W-1:0] DELAY_LAST = DELAY_W'(START_DELAY - 1);

    typedef enum logic [1:0] {
        ST_HOLD,
        ST_REQUEST,
        ST_WAIT,
        ST_ADVANCE
    } seq_state_t;

    seq_state_t         state;
    logic [DELAY_W-1:0] delay_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_HOLD;
            delay_cnt <= '0;
            start <= 1'b0;
            running <= 1'b0;
            tx_word <= TX_SEED;
        end else begin
            case (state)
                ST_HOLD: begin
                    // Power-up delay before the first transfer
                    if (delay_cnt == DELAY_LAST) begin
                        state <= ST_REQUEST;
                        start <= 1'b1;
                        running <= 1'b1;
                    end else begin
                        delay_cnt <= delay_cnt + DELAY_W'(1);
                    end
                end

                ST_REQUEST: begin
                    // Master has taken the word
                    if (busy) begin
                        start <= 1'b0;
                        state <= ST_WAIT;
                    end
                end

                ST_WAIT: begin
                    // tx_word stays put until done, the checker compares against it
                    if (done) begin
                        tx_word <= tx_word + TX_STEP;
                        state <= ST_ADVANCE;
                    end
                end

                ST_ADVANCE: begin
                    // One idle cycle keeps cs high between frames
                    start <= 1'b1;
                    state <= ST_REQUEST;
                end

                default: begin
                    state <= ST_HOLD;
                    start <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- design/spi_master.sv
module spi_master (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic [spi_loop_pkg::WORD_BITS-1:0] tx_word,
    input  logic                               miso,
    output logic                               busy,
    output logic                               done,
    output logic [spi_loop_pkg::WORD_BITS-1:0] rx_word,
    output logic                               sclk,
    output logic                               mosi,
    output logic                               cs
);
    import spi_loop_pkg::*;

    localparam int HALF_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
    localparam int BIT_W = (WORD_BITS > 1) ? $clog2(WORD_BITS) : 1;
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SCLK_HALF - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(WORD_BITS - 1);

    logic [HALF_W-1:0]    half_cnt;
    logic [BIT_W-1:0]     bit_cnt;
    logic [WORD_BITS-1:0] tx_shift;
    logic [WORD_BITS-1:0] rx_shift;

    logic accept;
    logic edge_tick;
    logic sclk_rise;
    logic sclk_fall;
    logic last_fall;

    // A request is only taken while idle
    assign accept = start && !busy;

    // End of a half period, the done cycle itself is excluded
    assign edge_tick = busy && !done && (half_cnt == HALF_LAST);
    assign sclk_rise = edge_tick && !sclk;
    assign sclk_fall = edge_tick && sclk;
    assign last_fall = sclk_fall && (bit_cnt == BIT_LAST);

    // MSB first, held low while deselected
    assign mosi = tx_shift[WORD_BITS-1] & ~cs;

    // Control path
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cs <= 1'b1;
            sclk <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cs <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
        end else if (done) begin
            // busy drops the cycle after the done pulse
            busy <= 1'b0;
            done <= 1'b0;
        end else if (edge_tick) begin
            half_cnt <= '0;
            sclk <= ~sclk;
            if (last_fall) begin
                cs <= 1'b1;
                done <= 1'b1;
            end else if (sclk_fall) begin
                bit_cnt <= bit_cnt + BIT_W'(1);
            end
        end else if (busy) begin
            half_cnt <= half_cnt + HALF_W'(1);
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_shift <= tx_word;
        end else if (sclk_fall) begin
            // Next bit goes out while SCLK is low
            tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b0};
        end

        if (sclk_rise) begin
            rx_shift <= {rx_shift[WORD_BITS-2:0], miso};
        end

        // Last bit was sampled on the preceding rising edge
        if (last_fall) begin
            rx_word <= rx_shift;
        end
    end

endmodule

//--- design/spi_loop_pkg.sv
package spi_loop_pkg;

    // Bits in one SPI transfer
    localparam int WORD_BITS = 16;

    // clk cycles per half SCLK period
    localparam int SCLK_HALF = 4;

    // Power-up hold-off after reset, in clk cycles
    localparam int START_DELAY = 480;

    // Transmit pattern: first word, then one step per transfer
    localparam logic [WORD_BITS-1:0] TX_SEED = WORD_BITS'(25);
    localparam logic [WORD_BITS-1:0] TX_STEP = WORD_BITS'(1);

    // Board LEDs are active low
    localparam logic LED_ON = 1'b0;
    localparam logic LED_OFF = 1'b1;

    // Low received bits shown on pins
    localparam int RX_PINS = 6;

endpackage
